/* src.f */
common/cpu_pkg.sv
common/mem_pkg.sv
common/mem_if.sv
core/decoder.sv
core/datapath.sv
rtl/i_cache.sv
rtl/d_cache.sv
rtl/mycpu_top.sv
tests/wb_checker.sv
tests/tb_top.sv

/* Bender.yml */
package:
  name: mycpu

sources:
  - common/cpu_pkg.sv
  - common/mem_pkg.sv
  - common/mem_if.sv
  - core/decoder.sv
  - core/datapath.sv
  - rtl/i_cache.sv
  - rtl/d_cache.sv
  - rtl/mycpu_top.sv
  - target: test
    files:
      - tests/wb_checker.sv
      - tests/tb_top.sv

/* tests/tb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam int PROG_ROWS   = 52;
    localparam int IMEM_WORDS  = 128;
    localparam int DMEM_WORDS  = 256;
    localparam int WATCHDOG_NS = (PROG_ROWS * 40 + 5) * 100;

    // physical image of RESET_PC after kseg1 folding
    localparam logic [31:0] IMEM_BASE = 32'h1fc0_0000;

    logic              clk;
    logic              rst;
    logic              inst_sram_en;
    cpu_pkg::word_t    inst_sram_addr;
    cpu_pkg::word_t    inst_sram_rdata;
    logic              data_sram_en;
    mem_pkg::byte_en_t data_sram_wen;
    cpu_pkg::word_t    data_sram_addr;
    cpu_pkg::word_t    data_sram_wdata;
    cpu_pkg::word_t    data_sram_rdata;
    logic              data_sram_data_ok;
    cpu_pkg::word_t    debug_wb_pc;
    mem_pkg::byte_en_t debug_wb_rf_wen;
    cpu_pkg::reg_idx_t debug_wb_rf_wnum;
    cpu_pkg::word_t    debug_wb_rf_wdata;

    logic              chk_done;
    int                errors;
    int                seen;
    int                expected_rows;

    cpu_pkg::word_t    prog [PROG_ROWS];
    cpu_pkg::word_t    imem [IMEM_WORDS];
    cpu_pkg::word_t    dmem [DMEM_WORDS];
    logic [31:0]       rng_state = 32'he052_6869;

    // requests are sampled mid-cycle and answered after the next edge
    logic              i_req;
    cpu_pkg::word_t    i_addr;
    logic              d_req;
    mem_pkg::byte_en_t d_wen;
    cpu_pkg::word_t    d_addr;
    cpu_pkg::word_t    d_wdata;
    int                d_wait;

    mycpu_top dut_i (
        .clk               (clk),
        .rst               (rst),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .data_sram_data_ok (data_sram_data_ok),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    wb_checker wb_checker_i (
        .clk               (clk),
        .rst               (rst),
        .inst_sram_en      (inst_sram_en),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .done              (chk_done),
        .errors            (errors),
        .seen              (seen),
        .expected_rows     (expected_rows)
    );

    function automatic cpu_pkg::word_t enc_r(logic [5:0] funct, logic [4:0] rs,
                                             logic [4:0] rt, logic [4:0] rd);
        return {cpu_pkg::OP_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic cpu_pkg::word_t enc_i(logic [5:0] op, logic [4:0] rs,
                                             logic [4:0] rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    always #50 clk = ~clk;

    always @(negedge clk) begin
        i_req   = inst_sram_en;
        i_addr  = inst_sram_addr;
        d_req   = data_sram_en;
        d_wen   = data_sram_wen;
        d_addr  = data_sram_addr;
        d_wdata = data_sram_wdata;
    end

    // instruction sram with one cycle of read latency
    always @(posedge clk) begin
        #10;
        if (i_req) begin
            if (i_addr - IMEM_BASE < 4 * IMEM_WORDS)
                inst_sram_rdata = imem[(i_addr - IMEM_BASE) >> 2];
            else
                inst_sram_rdata = '0;
        end
    end

    // data sram raises data_ok after 0 to 3 extra cycles
    always @(posedge clk) begin
        #10;
        if (data_sram_data_ok) begin
            data_sram_data_ok = 1'b0;
        end else if (d_req) begin
            if (d_wait < 0)
                d_wait = int'(xorshift32() % 4);
            if (d_wait == 0) begin
                if (d_addr < 4 * DMEM_WORDS) begin
                    for (int b = 0; b < 4; b++) begin
                        if (d_wen[b])
                            dmem[d_addr[9:2]][8*b +: 8] = d_wdata[8*b +: 8];
                    end
                    data_sram_rdata = dmem[d_addr[9:2]];
                end else begin
                    // unmapped addresses fall outside the model and read as all ones
                    data_sram_rdata = '1;
                end
                data_sram_data_ok = 1'b1;
                d_wait            = -1;
            end else begin
                d_wait = d_wait - 1;
            end
        end
    end

    initial begin
        clk               = 1'b0;
        rst               = 1'b1;
        inst_sram_rdata   = '0;
        data_sram_rdata   = '0;
        data_sram_data_ok = 1'b0;
        d_wait            = -1;
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = 32'(i * 4);
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = '0;

        // alu and immediates
        prog[0]  = enc_i(cpu_pkg::OP_LUI, 0, 1, 16'h8000);
        prog[1]  = enc_i(cpu_pkg::OP_ORI, 0, 2, 16'h0005);
        prog[2]  = enc_i(cpu_pkg::OP_ADDIU, 2, 3, 16'hfffe);
        prog[3]  = enc_r(cpu_pkg::FN_SUBU, 2, 3, 4);
        prog[4]  = enc_r(cpu_pkg::FN_AND, 2, 3, 5);
        prog[5]  = enc_r(cpu_pkg::FN_OR, 2, 3, 6);
        prog[6]  = enc_r(cpu_pkg::FN_SLT, 3, 2, 7);
        prog[7]  = enc_r(cpu_pkg::FN_SLT, 2, 3, 8);
        prog[8]  = enc_r(cpu_pkg::FN_ADDU, 2, 3, 0);
        prog[9]  = enc_i(cpu_pkg::OP_ADDIU, 0, 9, 16'hffff);
        prog[10] = enc_r(cpu_pkg::FN_SLT, 9, 0, 10);
        // loads and stores use a kseg0 base in r1 and a kseg1 base in r15
        prog[11] = enc_i(cpu_pkg::OP_SW, 1, 6, 16'h0010);
        prog[12] = enc_i(cpu_pkg::OP_LW, 1, 11, 16'h0010);
        prog[13] = enc_r(cpu_pkg::FN_ADDU, 11, 2, 12);
        prog[14] = enc_i(cpu_pkg::OP_LW, 1, 13, 16'h0010);
        prog[15] = enc_i(cpu_pkg::OP_LW, 1, 14, 16'h0024);
        prog[16] = enc_i(cpu_pkg::OP_LUI, 0, 15, 16'ha000);
        prog[17] = enc_i(cpu_pkg::OP_SW, 15, 2, 16'h0030);
        prog[18] = enc_i(cpu_pkg::OP_LW, 1, 16, 16'h0030);
        prog[19] = enc_i(cpu_pkg::OP_SW, 15, 3, 16'h0010);
        prog[20] = enc_i(cpu_pkg::OP_LW, 1, 17, 16'h0010);
        // branches with delay slots
        prog[21] = enc_i(cpu_pkg::OP_BEQ, 2, 3, 16'h0002);
        prog[22] = enc_i(cpu_pkg::OP_ADDIU, 0, 18, 16'h0001);
        prog[23] = enc_i(cpu_pkg::OP_ADDIU, 18, 18, 16'h0001);
        prog[24] = enc_i(cpu_pkg::OP_BNE, 2, 3, 16'h0002);
        prog[25] = enc_i(cpu_pkg::OP_ADDIU, 0, 19, 16'h0007);
        prog[26] = enc_i(cpu_pkg::OP_ADDIU, 0, 19, 16'h0063);
        prog[27] = enc_i(cpu_pkg::OP_BEQ, 2, 2, 16'h0002);
        prog[28] = enc_i(cpu_pkg::OP_ADDIU, 0, 20, 16'h0003);
        prog[29] = enc_i(cpu_pkg::OP_ADDIU, 0, 20, 16'h0058);
        // 19-word loop runs twice and overflows the i_cache
        prog[30] = enc_i(cpu_pkg::OP_ADDIU, 0, 21, 16'h0002);
        prog[31] = enc_i(cpu_pkg::OP_ADDIU, 0, 22, 16'h0000);
        for (int j = 0; j < 16; j++)
            prog[32 + j] = enc_i(cpu_pkg::OP_ADDIU, 22, 22, 16'h0001);
        prog[48] = enc_i(cpu_pkg::OP_ADDIU, 21, 21, 16'hffff);
        prog[49] = enc_i(cpu_pkg::OP_BNE, 21, 0, 16'hffee);
        prog[50] = enc_i(cpu_pkg::OP_ADDIU, 22, 23, 16'h0000);
        prog[51] = enc_i(cpu_pkg::OP_ADDIU, 0, 24, 16'h0055);

        for (int i = 0; i < PROG_ROWS; i++)
            imem[i] = prog[i];

        repeat (5) @(posedge clk);
        #10;
        rst = 1'b0;

        while (!chk_done)
            @(posedge clk);
        // leave room for an extra writeback to show up
        repeat (20) @(posedge clk);
        $display("writebacks checked: %0d of %0d, errors: %0d", seen, expected_rows, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout after %0d ns: only %0d of %0d writebacks seen, the core hung",
                 WATCHDOG_NS, seen, expected_rows);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/wb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_checker (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      inst_sram_en,
    input  wire                      data_sram_en,
    input  wire mem_pkg::byte_en_t   data_sram_wen,
    input  wire cpu_pkg::word_t      debug_wb_pc,
    input  wire mem_pkg::byte_en_t   debug_wb_rf_wen,
    input  wire cpu_pkg::reg_idx_t   debug_wb_rf_wnum,
    input  wire cpu_pkg::word_t      debug_wb_rf_wdata,
    output logic                     done,
    output int                       errors,
    output int                       seen,
    output int                       expected_rows
);

    cpu_pkg::word_t    exp_pc  [$];
    cpu_pkg::reg_idx_t exp_num [$];
    cpu_pkg::word_t    exp_val [$];

    task automatic expect_wb(input int k, input int num, input cpu_pkg::word_t val);
        exp_pc.push_back(cpu_pkg::RESET_PC + 32'(4 * k));
        exp_num.push_back(cpu_pkg::reg_idx_t'(num));
        exp_val.push_back(val);
    endtask

    task automatic report_mismatch(input string field, input cpu_pkg::word_t got,
                                   input cpu_pkg::word_t want);
        $display("[FAIL] %0t ns: writeback %0d has wrong %s, got %h expected %h",
                 $time, seen, field, got, want);
        errors++;
    endtask

    assign done = expected_rows > 0 && seen >= expected_rows;

    initial begin
        errors        = 0;
        seen          = 0;
        expected_rows = 0;
        expect_wb(0, 1, 32'h8000_0000);
        expect_wb(1, 2, 32'h0000_0005);
        expect_wb(2, 3, 32'h0000_0003);
        expect_wb(3, 4, 32'h0000_0002);
        expect_wb(4, 5, 32'h0000_0001);
        expect_wb(5, 6, 32'h0000_0007);
        expect_wb(6, 7, 32'h0000_0001);
        expect_wb(7, 8, 32'h0000_0000);
        expect_wb(9, 9, 32'hffff_ffff);
        expect_wb(10, 10, 32'h0000_0001);
        expect_wb(12, 11, 32'h0000_0007);
        expect_wb(13, 12, 32'h0000_000c);
        expect_wb(14, 13, 32'h0000_0007);
        expect_wb(15, 14, 32'h0000_0024);
        expect_wb(16, 15, 32'ha000_0000);
        expect_wb(18, 16, 32'h0000_0005);
        expect_wb(20, 17, 32'h0000_0003);
        expect_wb(22, 18, 32'h0000_0001);
        expect_wb(23, 18, 32'h0000_0002);
        expect_wb(25, 19, 32'h0000_0007);
        expect_wb(28, 20, 32'h0000_0003);
        expect_wb(30, 21, 32'h0000_0002);
        expect_wb(31, 22, 32'h0000_0000);
        for (int it = 0; it < 2; it++) begin
            for (int j = 0; j < 16; j++)
                expect_wb(32 + j, 22, 32'(it * 16 + j + 1));
            expect_wb(48, 21, 32'(1 - it));
            expect_wb(50, 23, 32'((it + 1) * 16));
        end
        expect_wb(51, 24, 32'h0000_0055);
        expected_rows = exp_pc.size();
    end

    // debug port is settled by mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            // request and write enables stay low while reset holds
            if (inst_sram_en !== 1'b0 || data_sram_en !== 1'b0 ||
                data_sram_wen !== '0 || debug_wb_rf_wen !== '0) begin
                $display("[FAIL] %0t ns: an sram or debug enable is not low during reset",
                         $time);
                errors++;
            end
        end else begin
            if ($isunknown(debug_wb_rf_wen)) begin
                $display("debug write enable is unknown at %0t ns", $time);
                errors++;
            end else if (debug_wb_rf_wen != '0) begin
                if (seen >= expected_rows) begin
                    $display("unexpected extra writeback at %0t ns: pc %h reg %0d data %h",
                             $time, debug_wb_pc, debug_wb_rf_wnum, debug_wb_rf_wdata);
                    errors++;
                end else begin
                    if (debug_wb_rf_wen != 4'hf)
                        report_mismatch("write enable", 32'(debug_wb_rf_wen), 32'hf);
                    if (debug_wb_pc != exp_pc[seen])
                        report_mismatch("pc", debug_wb_pc, exp_pc[seen]);
                    if (debug_wb_rf_wnum != exp_num[seen])
                        report_mismatch("register", 32'(debug_wb_rf_wnum), 32'(exp_num[seen]));
                    if (debug_wb_rf_wdata != exp_val[seen])
                        report_mismatch("data", debug_wb_rf_wdata, exp_val[seen]);
                end
                seen++;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/mycpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mycpu_top (
    input  wire                 clk,
    input  wire                 rst,

    output logic                inst_sram_en,
    output cpu_pkg::word_t      inst_sram_addr,
    input  wire cpu_pkg::word_t inst_sram_rdata,

    output logic                data_sram_en,
    output mem_pkg::byte_en_t   data_sram_wen,
    output cpu_pkg::word_t      data_sram_addr,
    output cpu_pkg::word_t      data_sram_wdata,
    input  wire cpu_pkg::word_t data_sram_rdata,
    input  wire                 data_sram_data_ok,

    output cpu_pkg::word_t      debug_wb_pc,
    output mem_pkg::byte_en_t   debug_wb_rf_wen,
    output cpu_pkg::reg_idx_t   debug_wb_rf_wnum,
    output cpu_pkg::word_t      debug_wb_rf_wdata
);

    mem_if imem ();
    mem_if dmem ();

    datapath datapath_i (
        .clk               (clk),
        .rst               (rst),
        .imem              (imem.core),
        .dmem              (dmem.core),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    i_cache i_cache_i (
        .clk             (clk),
        .rst             (rst),
        .core            (imem.cache),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata)
    );

    d_cache d_cache_i (
        .clk               (clk),
        .rst               (rst),
        .core              (dmem.cache),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .data_sram_data_ok (data_sram_data_ok)
    );

endmodule

`default_nettype wire

/* rtl/d_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module d_cache (
    input  wire                 clk,
    input  wire                 rst,
    mem_if.cache                core,
    output logic                data_sram_en,
    output mem_pkg::byte_en_t   data_sram_wen,
    output cpu_pkg::word_t      data_sram_addr,
    output cpu_pkg::word_t      data_sram_wdata,
    input  wire cpu_pkg::word_t data_sram_rdata,
    input  wire                 data_sram_data_ok
);

    typedef enum logic [1:0] {
        idle,
        wait_ok,
        done
    } state_t;

    state_t                    state;
    mem_pkg::addr_t            paddr;
    mem_pkg::index_t           idx;
    mem_pkg::tag_t             tag;
    logic                      uncached;
    logic                      is_write;
    logic                      line_match;
    logic                      hit;
    logic                      need_sram;
    logic                      finish;
    logic [mem_pkg::LINES-1:0] valid;
    mem_pkg::tag_t             tags [mem_pkg::LINES];
    cpu_pkg::word_t            data [mem_pkg::LINES];
    cpu_pkg::word_t            rdata_q;

    assign paddr    = mem_pkg::map_addr(core.addr);
    assign idx      = paddr[mem_pkg::INDEX_BITS+1:2];
    assign tag      = paddr[31:mem_pkg::INDEX_BITS+2];
    assign uncached = core.addr[31:29] == mem_pkg::KSEG1_TOP;
    assign is_write = |core.wen;

    // a kseg1 store still has to update a kseg0 copy of the same word
    assign line_match = valid[idx] && tags[idx] == tag;
    assign hit        = line_match && !uncached;
    assign need_sram  = core.en && (is_write || !hit);
    assign finish     = state == wait_ok && data_sram_data_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            valid <= '0;
        end else begin
            case (state)
                idle: begin
                    if (need_sram)
                        state <= wait_ok;
                end
                wait_ok: begin
                    if (data_sram_data_ok) begin
                        state <= done;
                        if (!is_write && !uncached)
                            valid[idx] <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            rdata_q <= data_sram_rdata;
            if (is_write) begin
                if (line_match) begin
                    for (int b = 0; b < 4; b++) begin
                        if (core.wen[b])
                            data[idx][8*b +: 8] <= core.wdata[8*b +: 8];
                    end
                end
            end else if (!uncached) begin
                tags[idx] <= tag;
                data[idx] <= data_sram_rdata;
            end
        end
    end

    assign data_sram_en    = state == wait_ok;
    assign data_sram_wen   = state == wait_ok ? core.wen : '0;
    assign data_sram_addr  = paddr;
    assign data_sram_wdata = core.wdata;

    assign core.rdata = state == done ? rdata_q : data[idx];
    assign core.stall = (state == idle && need_sram) || state == wait_ok;

endmodule

`default_nettype wire

/* rtl/i_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module i_cache (
    input  wire                 clk,
    input  wire                 rst,
    mem_if.cache                core,
    output logic                inst_sram_en,
    output cpu_pkg::word_t      inst_sram_addr,
    input  wire cpu_pkg::word_t inst_sram_rdata
);

    typedef enum logic [1:0] {
        idle,
        refill,
        done
    } state_t;

    state_t                    state;
    mem_pkg::addr_t            paddr;
    mem_pkg::index_t           idx;
    mem_pkg::tag_t             tag;
    logic                      hit;
    logic                      miss;
    logic [mem_pkg::LINES-1:0] valid;
    mem_pkg::tag_t             tags [mem_pkg::LINES];
    cpu_pkg::word_t            data [mem_pkg::LINES];

    assign paddr = mem_pkg::map_addr(core.addr);
    assign idx   = paddr[mem_pkg::INDEX_BITS+1:2];
    assign tag   = paddr[31:mem_pkg::INDEX_BITS+2];
    assign hit   = valid[idx] && tags[idx] == tag;
    assign miss  = state == idle && core.en && !hit;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            valid <= '0;
        end else begin
            case (state)
                idle: begin
                    if (miss)
                        state <= refill;
                end
                refill: begin
                    valid[idx] <= 1'b1;
                    state      <= done;
                end
                default: state <= idle;
            endcase
        end
    end

    // sram word arrives the cycle after the read
    always_ff @(posedge clk) begin
        if (state == refill) begin
            tags[idx] <= tag;
            data[idx] <= inst_sram_rdata;
        end
    end

    assign inst_sram_en   = miss;
    assign inst_sram_addr = paddr;

    // line is filled by done, so it answers as a hit
    assign core.rdata = data[idx];
    assign core.stall = miss || state == refill;

endmodule

`default_nettype wire

/* core/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module datapath (
    input  wire                clk,
    input  wire                rst,
    mem_if.core                imem,
    mem_if.core                dmem,
    output cpu_pkg::word_t     debug_wb_pc,
    output mem_pkg::byte_en_t  debug_wb_rf_wen,
    output cpu_pkg::reg_idx_t  debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    // fetch
    cpu_pkg::word_t    pc;
    cpu_pkg::word_t    pc_next;
    cpu_pkg::word_t    fetch_instr;
    cpu_pkg::word_t    instr_hold;
    logic              fetch_en;
    logic              imem_done;
    logic              imem_ok;

    // execute
    logic              e_valid;
    cpu_pkg::word_t    e_pc;
    cpu_pkg::word_t    instr;
    cpu_pkg::ctrl_t    ctrl;
    cpu_pkg::reg_idx_t rs;
    cpu_pkg::reg_idx_t rt;
    cpu_pkg::reg_idx_t dest;
    cpu_pkg::word_t    rs_val;
    cpu_pkg::word_t    rt_val;
    cpu_pkg::word_t    imm_ext;
    cpu_pkg::word_t    alu_b;
    cpu_pkg::word_t    alu_y;
    cpu_pkg::word_t    branch_target;
    cpu_pkg::word_t    load_data;
    cpu_pkg::word_t    load_hold;
    cpu_pkg::word_t    e_result;
    logic              taken;
    logic              dmem_req;
    logic              dmem_done;
    logic              dmem_ok;
    logic              advance;

    // writeback
    logic              w_reg_write;
    cpu_pkg::word_t    w_pc;
    cpu_pkg::reg_idx_t w_dest;
    cpu_pkg::word_t    w_result;

    cpu_pkg::word_t    regs [32];

    decoder decoder_i (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // writeback result is bypassed, it lands in regs only at the end of the cycle
    function automatic cpu_pkg::word_t read_reg(input cpu_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        if (w_reg_write && w_dest == idx)
            return w_result;
        return regs[idx];
    endfunction

    assign imem.en    = fetch_en && !imem_done;
    assign imem.addr  = pc;
    assign imem.wen   = '0;
    assign imem.wdata = '0;

    assign imem_ok     = imem_done || (imem.en && !imem.stall);
    assign fetch_instr = imem_done ? instr_hold : imem.rdata;

    assign rs   = instr[25:21];
    assign rt   = instr[20:16];
    assign dest = ctrl.dest_rt ? rt : instr[15:11];

    always_comb begin
        rs_val = read_reg(rs);
        rt_val = read_reg(rt);
    end

    assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign alu_b   = ctrl.alu_src_imm ? imm_ext : rt_val;

    always_comb begin
        case (ctrl.alu_op)
            cpu_pkg::alu_sub: alu_y = rs_val - alu_b;
            cpu_pkg::alu_and: alu_y = rs_val & alu_b;
            cpu_pkg::alu_or:  alu_y = rs_val | alu_b;
            cpu_pkg::alu_slt: alu_y = {31'b0, $signed(rs_val) < $signed(alu_b)};
            cpu_pkg::alu_lui: alu_y = {alu_b[15:0], 16'h0000};
            default:          alu_y = rs_val + alu_b;
        endcase
    end

    // target is relative to the delay slot
    assign branch_target = e_pc + 32'd4 + {imm_ext[29:0], 2'b00};
    assign taken = e_valid && ((ctrl.branch_eq && rs_val == rt_val) ||
                               (ctrl.branch_ne && rs_val != rt_val));
    assign pc_next = taken ? branch_target : pc + 32'd4;

    assign dmem_req   = e_valid && (ctrl.mem_read || ctrl.mem_write);
    assign dmem.en    = dmem_req && !dmem_done;
    assign dmem.wen   = {4{ctrl.mem_write}};
    assign dmem.addr  = alu_y;
    assign dmem.wdata = rt_val;

    assign dmem_ok   = !dmem_req || dmem_done || !dmem.stall;
    assign load_data = dmem_done ? load_hold : dmem.rdata;
    assign e_result  = ctrl.mem_read ? load_data : alu_y;

    // one port may finish while the other still stalls
    assign advance = imem_ok && dmem_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_en  <= 1'b0;
            imem_done <= 1'b0;
            dmem_done <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (advance) begin
                imem_done <= 1'b0;
                dmem_done <= 1'b0;
            end else begin
                if (imem.en && !imem.stall)
                    imem_done <= 1'b1;
                if (dmem.en && !dmem.stall)
                    dmem_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem.en && !imem.stall)
            instr_hold <= imem.rdata;
        if (dmem.en && !dmem.stall)
            load_hold <= dmem.rdata;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= cpu_pkg::RESET_PC;
            e_valid     <= 1'b0;
            w_reg_write <= 1'b0;
        end else if (advance) begin
            pc          <= pc_next;
            e_valid     <= 1'b1;
            w_reg_write <= e_valid && ctrl.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            e_pc     <= pc;
            instr    <= fetch_instr;
            w_pc     <= e_pc;
            w_dest   <= dest;
            w_result <= e_result;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && w_reg_write && w_dest != '0)
            regs[w_dest] <= w_result;
    end

    assign debug_wb_pc       = w_pc;
    assign debug_wb_rf_wen   = {4{advance && w_reg_write && w_dest != '0}};
    assign debug_wb_rf_wnum  = w_dest;
    assign debug_wb_rf_wdata = w_result;

endmodule

`default_nettype wire

/* core/decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire cpu_pkg::word_t instr,
    output cpu_pkg::ctrl_t      ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = cpu_pkg::alu_add;
        case (opcode)
            cpu_pkg::OP_SPECIAL: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    cpu_pkg::FN_ADDU: ctrl.alu_op = cpu_pkg::alu_add;
                    cpu_pkg::FN_SUBU: ctrl.alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::FN_AND:  ctrl.alu_op = cpu_pkg::alu_and;
                    cpu_pkg::FN_OR:   ctrl.alu_op = cpu_pkg::alu_or;
                    cpu_pkg::FN_SLT:  ctrl.alu_op = cpu_pkg::alu_slt;
                    // sll and friends fall here, so the all-zero nop writes nothing
                    default:          ctrl.reg_write = 1'b0;
                endcase
            end
            cpu_pkg::OP_ADDIU: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.dest_rt     = 1'b1;
            end
            cpu_pkg::OP_ORI: begin
                ctrl.reg_write    = 1'b1;
                ctrl.alu_src_imm  = 1'b1;
                ctrl.imm_zero_ext = 1'b1;
                ctrl.dest_rt      = 1'b1;
                ctrl.alu_op       = cpu_pkg::alu_or;
            end
            cpu_pkg::OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.dest_rt     = 1'b1;
                ctrl.alu_op      = cpu_pkg::alu_lui;
            end
            cpu_pkg::OP_LW: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.dest_rt     = 1'b1;
            end
            cpu_pkg::OP_SW: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            cpu_pkg::OP_BEQ: begin
                ctrl.branch_eq = 1'b1;
                ctrl.alu_op    = cpu_pkg::alu_sub;
            end
            cpu_pkg::OP_BNE: begin
                ctrl.branch_ne = 1'b1;
                ctrl.alu_op    = cpu_pkg::alu_sub;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* common/mem_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_if;

    logic              en;
    mem_pkg::byte_en_t wen;
    mem_pkg::addr_t    addr;
    cpu_pkg::word_t    wdata;
    cpu_pkg::word_t    rdata;
    logic              stall;

    // request side
    modport core (
        output en,
        output wen,
        output addr,
        output wdata,
        input  rdata,
        input  stall
    );

    modport cache (
        input  en,
        input  wen,
        input  addr,
        input  wdata,
        output rdata,
        output stall
    );

endinterface

`default_nettype wire

/* common/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    typedef logic [3:0] byte_en_t;
    typedef logic [31:0] addr_t;

    // one word per line
    localparam int LINES      = 16;
    localparam int INDEX_BITS = 4;
    localparam int TAG_BITS   = 32 - INDEX_BITS - 2;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    // kseg1 is the uncached window
    localparam logic [2:0] KSEG1_TOP = 3'b101;

    // kseg0 and kseg1 both fold onto the low 512 MB
    function automatic addr_t map_addr(input addr_t vaddr);
        return {3'b000, vaddr[28:0]};
    endfunction

endpackage

`default_nettype wire

/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_lui
    } alu_op_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // funct field under OP_SPECIAL
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    imm_zero_ext;
        logic    branch_eq;
        logic    branch_ne;
        logic    dest_rt;
        alu_op_t alu_op;
    } ctrl_t;

    localparam word_t RESET_PC = 32'hbfc0_0000;

endpackage

`default_nettype wire
